/* design/pma_pkg.sv */
// PMA checker shared types

package pma_pkg;

  // Upper bound on the region table, also the width of the match bitmap
  localparam int PMA_MAX_REGIONS = 16;

  // Access size encoding on the data side
  typedef logic [1:0] pma_size_t;
  localparam pma_size_t SIZE_BYTE = 2'd0;
  localparam pma_size_t SIZE_HALF = 2'd1;
  localparam pma_size_t SIZE_WORD = 2'd2;

  // One region, limit is inclusive
  typedef struct packed {
    logic [31:0] base;
    logic [31:0] limit;
    logic        main;
    logic        bufferable;
    logic        cacheable;
  } pma_region_t;

  typedef struct packed {
    logic [PMA_MAX_REGIONS-1:0] match_list;
    logic                       have_match;
    logic [3:0]                 match_idx;
    logic                       allow;
    logic                       main;
    logic                       bufferable;
    logic                       cacheable;
    logic                       misaligned;
  } pma_status_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        dbg;
  } instr_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    pma_size_t   size;
  } data_req_t;

  // Memory port payload, side is 0 for fetch and 1 for load/store
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    pma_size_t   size;
    logic        side;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        side;
  } pma_fault_t;

  typedef struct packed {
    logic [15:0] accesses;
    logic [15:0] faults;
    logic [15:0] multimatch;
    logic [15:0] nomatch;
    logic [15:0] misaligned;
    logic [15:0] stores;
  } pma_stats_t;

endpackage

/* design/pma_lookup.sv */
// PMA region lookup
`timescale 1ns/1ps

module pma_lookup
  import pma_pkg::*;
#(
  parameter int PMA_NUM_REGIONS = 8
) (
  input  logic [31:0] addr_i,
  input  pma_size_t   bytes_i,
  input  logic        is_instr_i,
  input  pma_region_t regions_i [PMA_NUM_REGIONS],
  output pma_status_t status_o
);

  logic [PMA_MAX_REGIONS-1:0] match_list;
  logic [3:0]                 match_idx;
  pma_region_t                hit;
  logic [2:0]                 nbytes;
  logic [2:0]                 end_off;
  logic                       misaligned;

  if (PMA_NUM_REGIONS < 1 || PMA_NUM_REGIONS > PMA_MAX_REGIONS) begin : g_bad_count
    $error("PMA_NUM_REGIONS out of range");
  end

  // One comparator pair per implemented region
  always_comb begin
    match_list = '0;
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      match_list[i] = (addr_i >= regions_i[i].base) && (addr_i <= regions_i[i].limit);
    end
  end

  // Lowest index wins, walk downwards so the last hit is the lowest
  always_comb begin
    match_idx = '0;
    hit       = '0;
    for (int i = PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (match_list[i]) begin
        match_idx = 4'(i);
        hit       = regions_i[i];
      end
    end
  end

  // Fetches are always word sized
  always_comb begin
    case (bytes_i)
      SIZE_BYTE: nbytes = 3'd1;
      SIZE_HALF: nbytes = 3'd2;
      default:   nbytes = 3'd4;
    endcase
    if (is_instr_i) nbytes = 3'd4;
  end

  assign end_off    = {1'b0, addr_i[1:0]} + nbytes;
  assign misaligned = end_off > 3'd4;

  always_comb begin
    status_o            = '0;
    status_o.match_list = match_list;
    status_o.have_match = |match_list;
    status_o.match_idx  = match_idx;
    status_o.misaligned = misaligned;
    // Unmapped space defaults to plain main memory
    status_o.main       = status_o.have_match ? hit.main : 1'b1;
    status_o.bufferable = status_o.have_match ? hit.bufferable : 1'b0;
    status_o.cacheable  = status_o.have_match ? hit.cacheable : 1'b0;
    // No execution from I/O, no misaligned access anywhere
    status_o.allow      = !misaligned && (status_o.main || !is_instr_i);
  end

endmodule

/* design/pma_mpu.sv */
// PMA checking MPU
`timescale 1ns/1ps

module pma_mpu
  import pma_pkg::*;
#(
  parameter bit  IS_INSTR_SIDE   = 1'b0,
  parameter int  PMA_NUM_REGIONS = 8,
  parameter type REQ_T           = data_req_t
) (
  input  logic        clk_ungated,
  input  logic        rst_n,
  input  REQ_T        core_req_i,
  input  logic        core_valid_i,
  output logic        core_ready_o,
  input  pma_region_t regions_i [PMA_NUM_REGIONS],
  output pma_status_t status_o,
  output bus_req_t    bus_req_o,
  output logic        bus_valid_o,
  input  logic        bus_ready_i,
  output pma_fault_t  fault_o,
  output logic        fault_valid_o
);

  logic [31:0] req_addr;
  logic        req_we;
  pma_size_t   req_size;
  logic        accept;
  bus_req_t    bus_req_q;
  logic        bus_valid_q;
  pma_fault_t  fault_q;
  logic        fault_valid_q;

  // Pick out the fields this side's request type carries
  if (IS_INSTR_SIDE) begin : g_instr
    assign req_addr = core_req_i.addr;
    assign req_we   = 1'b0;
    assign req_size = SIZE_WORD;
  end else begin : g_data
    assign req_addr = core_req_i.addr;
    assign req_we   = core_req_i.we;
    assign req_size = core_req_i.size;
  end

  pma_lookup #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS)
  ) lookup_i (
    .addr_i     (req_addr),
    .bytes_i    (req_size),
    .is_instr_i (IS_INSTR_SIDE),
    .regions_i  (regions_i),
    .status_o   (status_o)
  );

  // Free slot, or the slot empties this cycle
  assign core_ready_o = !bus_valid_q || bus_ready_i;
  assign accept       = core_valid_i && core_ready_o;

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      bus_valid_q   <= 1'b0;
      fault_valid_q <= 1'b0;
    end else begin
      if (accept && status_o.allow) begin
        bus_valid_q <= 1'b1;
      end else if (bus_ready_i) begin
        bus_valid_q <= 1'b0;
      end
      // Fault pulse lasts a single cycle
      fault_valid_q <= accept && !status_o.allow;
    end
  end

  always_ff @(posedge clk_ungated) begin
    if (accept && status_o.allow) begin
      bus_req_q.addr <= req_addr;
      bus_req_q.we   <= req_we;
      bus_req_q.size <= req_size;
      bus_req_q.side <= !IS_INSTR_SIDE;
    end
    if (accept && !status_o.allow) begin
      fault_q.addr <= req_addr;
      fault_q.side <= !IS_INSTR_SIDE;
    end
  end

  assign bus_req_o     = bus_req_q;
  assign bus_valid_o   = bus_valid_q;
  assign fault_o       = fault_q;
  assign fault_valid_o = fault_valid_q;

  // Core keeps a stalled request unchanged
  a_req_stable: assert property (
    @(posedge clk_ungated) disable iff (!rst_n)
    core_valid_i && !core_ready_o |=> $stable(core_req_i)
  );

endmodule

/* design/pma_access_monitor.sv */
// PMA access event counters
`timescale 1ns/1ps

module pma_access_monitor
  import pma_pkg::*;
#(
  parameter bit  IS_INSTR_SIDE   = 1'b0,
  parameter int  PMA_NUM_REGIONS = 8,
  parameter type REQ_T           = data_req_t
) (
  input  logic        clk_ungated,
  input  logic        rst_n,
  input  REQ_T        core_req_i,
  input  logic        core_valid_i,
  input  logic        core_ready_i,
  input  pma_status_t status_i,
  output pma_stats_t  stats_o
);

  logic       accept;
  logic       is_store;
  logic       multi;
  pma_stats_t stats_q;

  function automatic logic [15:0] sat_inc(input logic [15:0] cnt, input logic en);
    logic [15:0] nxt;
    nxt = cnt;
    // Hold at all ones
    if (en && (cnt != 16'hffff)) nxt = cnt + 16'd1;
    return nxt;
  endfunction

  assign accept = core_valid_i && core_ready_i;

  // Fetches never write
  if (IS_INSTR_SIDE) begin : g_instr
    assign is_store = 1'b0;
  end else begin : g_data
    assign is_store = core_req_i.we;
  end

  // Two or more bits set in the bitmap
  assign multi = (status_i.match_list & (status_i.match_list - 1'b1)) != '0;

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      stats_q <= '0;
    end else if (accept) begin
      stats_q.accesses   <= sat_inc(stats_q.accesses, 1'b1);
      stats_q.faults     <= sat_inc(stats_q.faults, !status_i.allow);
      stats_q.multimatch <= sat_inc(stats_q.multimatch, multi);
      stats_q.nomatch    <= sat_inc(stats_q.nomatch, !status_i.have_match);
      stats_q.misaligned <= sat_inc(stats_q.misaligned, status_i.misaligned);
      stats_q.stores     <= sat_inc(stats_q.stores, is_store);
    end
  end

  assign stats_o = stats_q;

  if (IS_INSTR_SIDE) begin : g_instr_checks
    // Winning region lies inside the implemented table
    a_match_idx: assert property (
      @(posedge clk_ungated) disable iff (!rst_n)
      accept && status_i.have_match |-> status_i.match_idx < PMA_NUM_REGIONS
    );
  end

endmodule

/* design/pma_bus_arbiter.sv */
// Round-robin memory port arbiter
`timescale 1ns/1ps

module pma_bus_arbiter
  import pma_pkg::*;
(
  input  logic     clk_ungated,
  input  logic     rst_n,
  input  bus_req_t instr_req_i,
  input  logic     instr_valid_i,
  output logic     instr_ready_o,
  input  bus_req_t data_req_i,
  input  logic     data_valid_i,
  output logic     data_ready_o,
  output bus_req_t mem_req_o,
  output logic     mem_valid_o,
  input  logic     mem_ready_i
);

  logic last_data_q;
  logic hold_q;
  logic hold_data_q;
  logic pick_data;

  // A stalled transfer keeps its side, otherwise the side not served last goes first
  always_comb begin
    if (hold_q) begin
      pick_data = hold_data_q;
    end else begin
      pick_data = data_valid_i && (!instr_valid_i || !last_data_q);
    end
  end

  assign mem_valid_o   = instr_valid_i || data_valid_i;
  assign mem_req_o     = pick_data ? data_req_i : instr_req_i;
  assign data_ready_o  = data_valid_i && pick_data && mem_ready_i;
  assign instr_ready_o = instr_valid_i && !pick_data && mem_ready_i;

  // Reset value gives the data side the first turn
  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      last_data_q <= 1'b0;
      hold_q      <= 1'b0;
      hold_data_q <= 1'b0;
    end else begin
      if (mem_valid_o && mem_ready_i) begin
        last_data_q <= pick_data;
      end
      hold_q      <= mem_valid_o && !mem_ready_i;
      hold_data_q <= pick_data;
    end
  end

  // Stalled request stays on the port until taken
  a_mem_hold: assert property (
    @(posedge clk_ungated) disable iff (!rst_n)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_req_o)
  );

endmodule

/* design/pma_subsystem_top.sv */
// PMA checker subsystem
`timescale 1ns/1ps

module pma_subsystem_top
  import pma_pkg::*;
#(
  parameter int PMA_NUM_REGIONS = 8
) (
  input  logic        clk_ungated,
  input  logic        rst_n,
  input  pma_region_t regions_i [PMA_NUM_REGIONS],
  input  instr_req_t  instr_req_i,
  input  logic        instr_valid_i,
  output logic        instr_ready_o,
  input  data_req_t   data_req_i,
  input  logic        data_valid_i,
  output logic        data_ready_o,
  output bus_req_t    mem_req_o,
  output logic        mem_valid_o,
  input  logic        mem_ready_i,
  output pma_fault_t  instr_fault_o,
  output logic        instr_fault_valid_o,
  output pma_fault_t  data_fault_o,
  output logic        data_fault_valid_o,
  output pma_stats_t  instr_stats_o,
  output pma_stats_t  data_stats_o
);

  pma_status_t instr_status;
  pma_status_t data_status;
  bus_req_t    instr_bus_req;
  bus_req_t    data_bus_req;
  logic        instr_bus_valid;
  logic        data_bus_valid;
  logic        instr_bus_ready;
  logic        data_bus_ready;

  // Fetch side
  pma_mpu #(
    .IS_INSTR_SIDE   (1'b1),
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .REQ_T           (instr_req_t)
  ) instr_mpu_i (
    .clk_ungated   (clk_ungated),
    .rst_n         (rst_n),
    .core_req_i    (instr_req_i),
    .core_valid_i  (instr_valid_i),
    .core_ready_o  (instr_ready_o),
    .regions_i     (regions_i),
    .status_o      (instr_status),
    .bus_req_o     (instr_bus_req),
    .bus_valid_o   (instr_bus_valid),
    .bus_ready_i   (instr_bus_ready),
    .fault_o       (instr_fault_o),
    .fault_valid_o (instr_fault_valid_o)
  );

  pma_access_monitor #(
    .IS_INSTR_SIDE   (1'b1),
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .REQ_T           (instr_req_t)
  ) instr_mon_i (
    .clk_ungated  (clk_ungated),
    .rst_n        (rst_n),
    .core_req_i   (instr_req_i),
    .core_valid_i (instr_valid_i),
    .core_ready_i (instr_ready_o),
    .status_i     (instr_status),
    .stats_o      (instr_stats_o)
  );

  // Load/store side
  pma_mpu #(
    .IS_INSTR_SIDE   (1'b0),
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .REQ_T           (data_req_t)
  ) data_mpu_i (
    .clk_ungated   (clk_ungated),
    .rst_n         (rst_n),
    .core_req_i    (data_req_i),
    .core_valid_i  (data_valid_i),
    .core_ready_o  (data_ready_o),
    .regions_i     (regions_i),
    .status_o      (data_status),
    .bus_req_o     (data_bus_req),
    .bus_valid_o   (data_bus_valid),
    .bus_ready_i   (data_bus_ready),
    .fault_o       (data_fault_o),
    .fault_valid_o (data_fault_valid_o)
  );

  pma_access_monitor #(
    .IS_INSTR_SIDE   (1'b0),
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .REQ_T           (data_req_t)
  ) data_mon_i (
    .clk_ungated  (clk_ungated),
    .rst_n        (rst_n),
    .core_req_i   (data_req_i),
    .core_valid_i (data_valid_i),
    .core_ready_i (data_ready_o),
    .status_i     (data_status),
    .stats_o      (data_stats_o)
  );

  pma_bus_arbiter arb_i (
    .clk_ungated   (clk_ungated),
    .rst_n         (rst_n),
    .instr_req_i   (instr_bus_req),
    .instr_valid_i (instr_bus_valid),
    .instr_ready_o (instr_bus_ready),
    .data_req_i    (data_bus_req),
    .data_valid_i  (data_bus_valid),
    .data_ready_o  (data_bus_ready),
    .mem_req_o     (mem_req_o),
    .mem_valid_o   (mem_valid_o),
    .mem_ready_i   (mem_ready_i)
  );

endmodule

/* test/tb_pma_subsystem.sv */
// PMA subsystem testbench
`timescale 1ns/1ps

module tb_pma_subsystem
  import pma_pkg::*;
();

  localparam int NUM_REGIONS    = 8;
  localparam int NUM_STIM       = 16;
  localparam int TIMEOUT_CYCLES = 40 * NUM_STIM + 100;

  // One table row, side is 0 for fetch and 1 for load/store
  typedef struct packed {
    logic        side;
    logic [31:0] addr;
    logic        we;
    pma_size_t   size;
    logic        to_bus;
  } stim_t;

  typedef struct packed {
    logic allow;
    logic multi;
    logic nomatch;
    logic misaligned;
  } outcome_t;

  // side, address, we, size, expected to reach the bus
  localparam stim_t STIM [NUM_STIM] = '{
    '{1'b0, 32'h0000_0100, 1'b0, SIZE_WORD, 1'b1},
    '{1'b1, 32'h0000_0200, 1'b0, SIZE_WORD, 1'b1},
    '{1'b0, 32'h0000_1100, 1'b0, SIZE_WORD, 1'b0},
    '{1'b1, 32'h0000_0902, 1'b1, SIZE_WORD, 1'b0},
    '{1'b1, 32'h0000_1800, 1'b1, SIZE_WORD, 1'b1},
    '{1'b0, 32'h0000_0A00, 1'b0, SIZE_WORD, 1'b1},
    '{1'b1, 32'h0000_2000, 1'b0, SIZE_HALF, 1'b1},
    '{1'b0, 32'h0000_3000, 1'b0, SIZE_WORD, 1'b1},
    '{1'b1, 32'h0000_0103, 1'b0, SIZE_HALF, 1'b0},
    '{1'b1, 32'h0000_0103, 1'b1, SIZE_BYTE, 1'b1},
    '{1'b0, 32'h0000_0002, 1'b0, SIZE_WORD, 1'b0},
    '{1'b1, 32'h0000_1004, 1'b0, SIZE_WORD, 1'b1},
    '{1'b0, 32'h0000_0800, 1'b0, SIZE_WORD, 1'b1},
    '{1'b1, 32'h0000_0F00, 1'b1, SIZE_HALF, 1'b1},
    '{1'b0, 32'h0000_0104, 1'b0, SIZE_WORD, 1'b1},
    '{1'b1, 32'h0000_0300, 1'b1, SIZE_WORD, 1'b1}
  };

  logic        clk_ungated;
  logic        rst_n;
  pma_region_t regions [NUM_REGIONS];
  instr_req_t  instr_req_i;
  logic        instr_valid_i;
  logic        instr_ready_o;
  data_req_t   data_req_i;
  logic        data_valid_i;
  logic        data_ready_o;
  bus_req_t    mem_req_o;
  logic        mem_valid_o;
  logic        mem_ready_i;
  pma_fault_t  instr_fault_o;
  logic        instr_fault_valid_o;
  pma_fault_t  data_fault_o;
  logic        data_fault_valid_o;
  pma_stats_t  instr_stats_o;
  pma_stats_t  data_stats_o;

  // Reference model state
  bus_req_t   exp_bus_instr [$];
  bus_req_t   exp_bus_data [$];
  pma_fault_t exp_fault_instr [$];
  pma_fault_t exp_fault_data [$];
  pma_stats_t exp_instr_stats;
  pma_stats_t exp_data_stats;
  int         cycles;
  logic       held;
  bus_req_t   held_req;
  logic       last_side;

  pma_subsystem_top #(
    .PMA_NUM_REGIONS (NUM_REGIONS)
  ) dut_i (
    .clk_ungated         (clk_ungated),
    .rst_n               (rst_n),
    .regions_i           (regions),
    .instr_req_i         (instr_req_i),
    .instr_valid_i       (instr_valid_i),
    .instr_ready_o       (instr_ready_o),
    .data_req_i          (data_req_i),
    .data_valid_i        (data_valid_i),
    .data_ready_o        (data_ready_o),
    .mem_req_o           (mem_req_o),
    .mem_valid_o         (mem_valid_o),
    .mem_ready_i         (mem_ready_i),
    .instr_fault_o       (instr_fault_o),
    .instr_fault_valid_o (instr_fault_valid_o),
    .data_fault_o        (data_fault_o),
    .data_fault_valid_o  (data_fault_valid_o),
    .instr_stats_o       (instr_stats_o),
    .data_stats_o        (data_stats_o)
  );

  always #5 clk_ungated = ~clk_ungated;

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_bus(input bus_req_t got, input bus_req_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("mem_req addr=%h we=%b size=%0d side=%b, expected %h %b %0d %b",
                               got.addr, got.we, got.size, got.side,
                               exp.addr, exp.we, exp.size, exp.side));
    end
  endtask

  task automatic check_fault(input pma_fault_t got, input pma_fault_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("fault addr=%h side=%b, expected addr=%h side=%b",
                               got.addr, got.side, exp.addr, exp.side));
    end
  endtask

  task automatic check_stats(input pma_stats_t got, input pma_stats_t exp, input string side);
    if (got !== exp) begin
      report_mismatch($sformatf("%s stats %0d/%0d/%0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d/%0d/%0d",
                               side, got.accesses, got.faults, got.multimatch, got.nomatch,
                               got.misaligned, got.stores, exp.accesses, exp.faults,
                               exp.multimatch, exp.nomatch, exp.misaligned, exp.stores));
    end
  endtask

  // Lookup rule applied to the fixed region table
  function automatic outcome_t predict(input stim_t s);
    outcome_t o;
    int       hits;
    int       first;
    int       nbytes;
    logic     main_attr;
    hits  = 0;
    first = -1;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (s.addr >= regions[i].base && s.addr <= regions[i].limit) begin
        hits++;
        if (first < 0) first = i;
      end
    end
    main_attr = (first < 0) ? 1'b1 : regions[first].main;
    if (!s.side || s.size == SIZE_WORD) nbytes = 4;
    else if (s.size == SIZE_HALF) nbytes = 2;
    else nbytes = 1;
    o.misaligned = (int'(s.addr[1:0]) + nbytes) > 4;
    o.multi      = hits >= 2;
    o.nomatch    = hits == 0;
    o.allow      = !o.misaligned && (main_attr || s.side);
    return o;
  endfunction

  function automatic pma_stats_t add_event(input pma_stats_t st, input outcome_t o,
                                           input logic store);
    pma_stats_t n;
    n            = st;
    n.accesses   = st.accesses + 16'd1;
    n.faults     = st.faults + 16'(!o.allow);
    n.multimatch = st.multimatch + 16'(o.multi);
    n.nomatch    = st.nomatch + 16'(o.nomatch);
    n.misaligned = st.misaligned + 16'(o.misaligned);
    n.stores     = st.stores + 16'(store);
    return n;
  endfunction

  // Called on the negedge before the accepting edge
  task automatic record_expected(input int idx, input stim_t s);
    outcome_t   o;
    bus_req_t   b;
    pma_fault_t f;
    o = predict(s);
    if (o.allow != s.to_bus) begin
      $display("Stimulus table entry %0d disagrees with the lookup model", idx);
      abort_run();
    end
    b.addr = s.addr;
    b.we   = s.side ? s.we : 1'b0;
    b.size = s.side ? s.size : SIZE_WORD;
    b.side = s.side;
    f.addr = s.addr;
    f.side = s.side;
    if (s.side) begin
      if (o.allow) exp_bus_data.push_back(b);
      else exp_fault_data.push_back(f);
      exp_data_stats = add_event(exp_data_stats, o, s.we);
    end else begin
      if (o.allow) exp_bus_instr.push_back(b);
      else exp_fault_instr.push_back(f);
      exp_instr_stats = add_event(exp_instr_stats, o, 1'b0);
    end
  endtask

  task automatic drive_fetches();
    for (int i = 0; i < NUM_STIM; i++) begin
      if (!STIM[i].side) begin
        @(posedge clk_ungated);
        instr_req_i   <= '{addr: STIM[i].addr, dbg: 1'b0};
        instr_valid_i <= 1'b1;
        @(negedge clk_ungated);
        while (!instr_ready_o) @(negedge clk_ungated);
        record_expected(i, STIM[i]);
        @(posedge clk_ungated);
        instr_valid_i <= 1'b0;
      end
    end
  endtask

  task automatic drive_loads_stores();
    for (int i = 0; i < NUM_STIM; i++) begin
      if (STIM[i].side) begin
        @(posedge clk_ungated);
        data_req_i   <= '{addr: STIM[i].addr, we: STIM[i].we, size: STIM[i].size};
        data_valid_i <= 1'b1;
        @(negedge clk_ungated);
        while (!data_ready_o) @(negedge clk_ungated);
        record_expected(i, STIM[i]);
        @(posedge clk_ungated);
        data_valid_i <= 1'b0;
      end
    end
  endtask

  // Memory side accepts at random
  always @(posedge clk_ungated) begin
    if (!rst_n) mem_ready_i <= 1'b0;
    else mem_ready_i <= ($urandom % 3) != 0;
  end

  always @(posedge clk_ungated) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: no response arrived within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // Port and fault monitor, sampled mid-cycle
  always @(negedge clk_ungated) begin
    if (rst_n) begin
      if (mem_valid_o) begin
        if (held) begin
          check_bus(mem_req_o, held_req);
        end else if (dut_i.instr_bus_valid && dut_i.data_bus_valid &&
                     mem_req_o.side === last_side) begin
          report_mismatch($sformatf("arbiter served side %b twice while both waited",
                                   last_side));
        end
        if (mem_ready_i) begin
          if (mem_req_o.side && exp_bus_data.size() == 0)
            report_mismatch("unexpected memory transfer from the data side");
          else if (!mem_req_o.side && exp_bus_instr.size() == 0)
            report_mismatch("unexpected memory transfer from the fetch side");
          else if (mem_req_o.side)
            check_bus(mem_req_o, exp_bus_data.pop_front());
          else
            check_bus(mem_req_o, exp_bus_instr.pop_front());
          last_side = mem_req_o.side;
        end
      end
      held     = mem_valid_o && !mem_ready_i;
      held_req = mem_req_o;
      if (instr_fault_valid_o) begin
        if (exp_fault_instr.size() == 0) report_mismatch("unexpected fetch fault");
        else check_fault(instr_fault_o, exp_fault_instr.pop_front());
      end
      if (data_fault_valid_o) begin
        if (exp_fault_data.size() == 0) report_mismatch("unexpected data fault");
        else check_fault(data_fault_o, exp_fault_data.pop_front());
      end
    end
  end

  initial begin
    int seed;
    seed            = 82;
    void'($urandom(seed));
    clk_ungated     = 1'b0;
    rst_n           = 1'b0;
    instr_req_i     = '0;
    instr_valid_i   = 1'b0;
    data_req_i      = '0;
    data_valid_i    = 1'b0;
    mem_ready_i     = 1'b0;
    exp_instr_stats = '0;
    exp_data_stats  = '0;
    cycles          = 0;
    held            = 1'b0;
    held_req        = '0;
    // Reset priority goes to the data side
    last_side       = 1'b0;
    // Unused entries have base above limit and never match
    for (int i = 0; i < NUM_REGIONS; i++) begin
      regions[i] = '{base: 32'hFFFF_FFFF, limit: 32'h0, main: 1'b1,
                     bufferable: 1'b0, cacheable: 1'b0};
    end
    regions[0] = '{base: 32'h0000_0000, limit: 32'h0000_0FFF, main: 1'b1,
                   bufferable: 1'b0, cacheable: 1'b1};
    regions[1] = '{base: 32'h0000_1000, limit: 32'h0000_1FFF, main: 1'b0,
                   bufferable: 1'b1, cacheable: 1'b0};
    regions[2] = '{base: 32'h0000_0800, limit: 32'h0000_17FF, main: 1'b1,
                   bufferable: 1'b0, cacheable: 1'b0};

    repeat (4) @(posedge clk_ungated);
    rst_n <= 1'b1;
    @(negedge clk_ungated);
    if (!instr_ready_o || !data_ready_o || mem_valid_o)
      report_mismatch("handshake outputs not idle after reset");
    check_stats(instr_stats_o, '0, "fetch");
    check_stats(data_stats_o, '0, "data");

    fork
      drive_fetches();
      drive_loads_stores();
    join

    while (exp_bus_instr.size() != 0 || exp_bus_data.size() != 0 ||
           exp_fault_instr.size() != 0 || exp_fault_data.size() != 0) begin
      @(posedge clk_ungated);
    end
    repeat (2) @(posedge clk_ungated);
    @(negedge clk_ungated);
    check_stats(instr_stats_o, exp_instr_stats, "fetch");
    check_stats(data_stats_o, exp_data_stats, "data");
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* tb.f */
design/pma_pkg.sv
design/pma_lookup.sv
design/pma_mpu.sv
design/pma_access_monitor.sv
design/pma_bus_arbiter.sv
design/pma_subsystem_top.sv
test/tb_pma_subsystem.sv

/* Bender.yml */
package:
  name: pma_subsystem

sources:
  - files:
      - design/pma_pkg.sv
      - design/pma_lookup.sv
      - design/pma_mpu.sv
      - design/pma_access_monitor.sv
      - design/pma_bus_arbiter.sv
      - design/pma_subsystem_top.sv
  - target: test
    files:
      - test/tb_pma_subsystem.sv
